//--- tb.f
+incdir+rtl
rtl/acq_sample_pkg.sv
rtl/acq_ctrl_pkg.sv
rtl/capture_channel.sv
rtl/cross_correlator.sv
rtl/acq_controller.sv
rtl/acoustic_acq_top.sv
tb/acq_assertions.sv
tb/acq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -f tb.f --top-module acq_tb -o acq_sim > build.log 2>&1 ||
    { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/acq_sim > "$LOG" 2>&1
grep -q "TESTS FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "TESTS PASSED" "$LOG" || { echo "Simulation ended without a result, see $LOG"; exit 1; }
echo "Simulation passed"

//--- tb/acq_tb.sv
// Sends whole 14-bit samples only, so both channels stay framed; each capture needs a pre-trigger sample
`timescale 1ns/1ps
`include "acq_consts.svh"

module acq_tb
    import acq_sample_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRV_DLY      = 2;
    localparam int RESET_CYCLES = 8;
    localparam int DONE_TIMEOUT = 1000;     // Cycles, far above one correlation
    localparam int QUIET_CYCLES = 200;

    typedef sample_t sample_buf_t [`ACQ_BUF_DEPTH];

    typedef struct packed {
        lag_t      lag;
        corr_sum_t sum;
    } corr_res_t;

    logic      clk;
    logic      reset_b;
    logic      run;
    logic      trig;
    logic      bit_en;
    logic      mic_a;
    logic      mic_b;
    logic      busy;
    logic      done;
    lag_t      best_lag;
    corr_sum_t best_sum;

    integer    seed;
    int        err_cnt;
    int        done_cnt;
    int        test_num;
    int        test_fail;
    int        test_err_start;
    corr_res_t exp_q [$];                  // One entry per capture awaiting done

    acoustic_acq_top acoustic_acq_top_i (
        .clk      (clk),
        .reset_b  (reset_b),
        .run      (run),
        .trig     (trig),
        .bit_en   (bit_en),
        .mic_a    (mic_a),
        .mic_b    (mic_b),
        .busy     (busy),
        .done     (done),
        .best_lag (best_lag),
        .best_sum (best_sum)
    );

    bind acq_controller acq_assertions acq_assertions_i (
        .clk        (clk),
        .reset_b    (reset_b),
        .state      (state),
        .store_en   (store_en),
        .corr_start (corr_start),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Best lag by the rule: largest sum of a[i]*b[i+lag], lowest lag on a tie
    function automatic corr_res_t ref_correlate(input sample_buf_t a, input sample_buf_t b);
        corr_res_t res;
        longint    sum;
        longint    best;
        int        best_idx;
        int        lag;
        int        i;
        best     = 0;
        best_idx = 0;
        for (lag = 0; lag < `ACQ_NUM_LAGS; lag++)
        begin
            sum = 0;
            for (i = 0; i + lag < `ACQ_BUF_DEPTH; i++)
                sum += longint'(a[i]) * longint'(b[i + lag]);
            if (lag == 0 || sum > best)
            begin
                best     = sum;
                best_idx = lag;
            end
        end
        res.lag = lag_t'(best_idx);
        res.sum = corr_sum_t'(best);
        return res;
    endfunction

    // Mostly random words, with full-scale values mixed in
    function automatic sample_t rand_sample();
        int r;
        r = $random(seed);
        if (r[3:0] == 4'd0)
            return {1'b1, {(`ACQ_SAMPLE_W-1){1'b0}}};
        else if (r[3:0] == 4'd1)
            return {1'b0, {(`ACQ_SAMPLE_W-1){1'b1}}};
        else
            return r[`ACQ_SAMPLE_W+3:4];
    endfunction

    task automatic check_lag(input lag_t got, input lag_t want);
        if (got !== want)
        begin
            $display("FAIL best_lag: got 0x%h, expected 0x%h", got, want);
            err_cnt++;
        end
    endtask

    task automatic check_sum(input corr_sum_t got, input corr_sum_t want);
        if (got !== want)
        begin
            $display("FAIL best_sum: got 0x%h, expected 0x%h", got, want);
            err_cnt++;
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRV_DLY;
    endtask

    // One sample per mic, MSB first, optional idle cycles before each bit
    task automatic send_pair(input sample_t sa, input sample_t sb, input bit gaps);
        int gap;
        int k;
        for (k = `ACQ_SAMPLE_W - 1; k >= 0; k--)
        begin
            if (gaps)
            begin
                gap    = $random(seed) & 3;
                bit_en = 1'b0;
                repeat (gap)
                    step();
            end
            bit_en = 1'b1;
            mic_a  = sa[k];
            mic_b  = sb[k];
            step();
        end
        bit_en = 1'b0;
    endtask

    task automatic run_capture(input int pre_cnt, input sample_buf_t a,
                               input sample_buf_t b, input bit gaps);
        int n;
        exp_q.push_back(ref_correlate(a, b));
        run = 1'b1;
        step();
        run = 1'b0;
        for (n = 0; n < pre_cnt; n++)
            send_pair(rand_sample(), rand_sample(), gaps);
        trig = 1'b1;                        // Seen at the boundary after the last pre sample
        for (n = 0; n < `ACQ_BUF_DEPTH; n++)
            send_pair(a[n], b[n], gaps);
        trig = 1'b0;
    endtask

    task automatic wait_done(input int start_cnt);
        int cycles;
        cycles = 0;
        while (done_cnt == start_cnt && cycles < DONE_TIMEOUT)
        begin
            step();
            cycles++;
        end
        if (done_cnt == start_cnt)
        begin
            $display("Timed out after %0d cycles waiting for done", DONE_TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_cnt - test_err_start;
        test_num++;
        if (errs == 0)
            $display("Test %0d %s: ok", test_num, name);
        else
        begin
            $display("Test %0d %s: %0d errors", test_num, name, errs);
            test_fail++;
        end
        test_err_start = err_cnt;
    endtask

    // Compare process, mid-cycle so done and the results are settled
    always @(negedge clk)
    begin : compare_on_done
        corr_res_t want;
        if (reset_b && done)
        begin
            done_cnt++;
            if (exp_q.size() == 0)
            begin
                $display("A done pulse arrived with no capture pending");
                err_cnt++;
            end
            else
            begin
                want = exp_q.pop_front();
                check_lag(best_lag, want.lag);
                check_sum(best_sum, want.sum);
            end
        end
    end

    initial
    begin
        sample_buf_t a;
        sample_buf_t b;
        corr_res_t   res;
        int          i;
        int          n;
        int          start;
        seed    = 47;
        run     = 1'b0;
        trig    = 1'b0;
        bit_en  = 1'b0;
        mic_a   = 1'b0;
        mic_b   = 1'b0;
        reset_b = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge clk);
        #DRV_DLY;
        reset_b = 1'b1;
        step();

        // Quiet after reset, bits alone start nothing
        verify_flag("busy", busy, 1'b0);
        verify_flag("done", done, 1'b0);
        check_lag(best_lag, '0);
        check_sum(best_sum, '0);
        for (n = 0; n < 4; n++)
            send_pair(rand_sample(), rand_sample(), 1'b1);
        for (i = 0; i < QUIET_CYCLES; i++)
            step();
        if (done_cnt != 0)
        begin
            $display("A done pulse appeared without a run");
            err_cnt++;
        end
        verify_flag("busy", busy, 1'b0);
        end_test("reset state");

        // B is A delayed by three samples
        for (i = 0; i < `ACQ_BUF_DEPTH; i++)
            a[i] = '0;
        a[2] = sample_t'(4000);
        a[3] = sample_t'(-3000);
        a[4] = sample_t'(2000);
        a[9] = sample_t'(1500);
        for (i = 0; i < `ACQ_BUF_DEPTH; i++)
        begin
            if (i >= 3)
                b[i] = a[i - 3];
            else
                b[i] = '0;
        end
        start = done_cnt;
        run_capture(2, a, b, 1'b0);
        wait_done(start);
        check_lag(best_lag, lag_t'(3));
        end_test("delay of three samples");

        for (i = 0; i < `ACQ_BUF_DEPTH; i++)
        begin
            a[i] = rand_sample();
            b[i] = rand_sample();
        end
        start = done_cnt;
        run_capture(5, a, b, 1'b1);
        wait_done(start);
        end_test("pre-trigger samples excluded");

        for (n = 0; n < 20; n++)
        begin
            for (i = 0; i < `ACQ_BUF_DEPTH; i++)
            begin
                a[i] = rand_sample();
                b[i] = rand_sample();
            end
            start = done_cnt;
            run_capture(1 + ($random(seed) & 3), a, b, 1'b1);
            wait_done(start);
        end
        end_test("random captures");

        for (i = 0; i < `ACQ_BUF_DEPTH; i++)
        begin
            a[i] = sample_t'(5000);
            b[i] = sample_t'(5000);
        end
        start = done_cnt;
        run_capture(1, a, b, 1'b0);
        wait_done(start);
        check_lag(best_lag, '0);
        for (i = 0; i < `ACQ_BUF_DEPTH; i++)
        begin
            a[i] = '0;
            b[i] = '0;
        end
        start = done_cnt;
        run_capture(1, a, b, 1'b1);
        wait_done(start);
        check_lag(best_lag, '0);
        check_sum(best_sum, '0);
        end_test("constant and zero inputs");

        // Second run lands while the correlator works
        for (i = 0; i < `ACQ_BUF_DEPTH; i++)
        begin
            a[i] = rand_sample();
            b[i] = rand_sample();
        end
        res   = ref_correlate(a, b);
        start = done_cnt;
        run_capture(2, a, b, 1'b0);
        repeat (5)
            step();
        verify_flag("busy", busy, 1'b1);
        run = 1'b1;
        step();
        run = 1'b0;
        wait_done(start);
        for (i = 0; i < QUIET_CYCLES; i++)
            step();
        if (done_cnt != start + 1)
        begin
            $display("Expected one done pulse after a run while busy, saw %0d", done_cnt - start);
            err_cnt++;
        end
        verify_flag("busy", busy, 1'b0);
        check_lag(best_lag, res.lag);
        check_sum(best_sum, res.sum);
        end_test("run while busy");

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 test_num, test_num - test_fail, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- tb/acq_assertions.sv
// Controller protocol checks, bound into acq_controller; all properties are off while reset_b is low
`timescale 1ns/1ps

module acq_assertions
    import acq_ctrl_pkg::*;
(
    input logic       clk,
    input logic       reset_b,
    input acq_state_t state,
    input logic       store_en,
    input logic       corr_start,
    input logic       busy,
    input logic       done
);

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_b) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Storing only happens after the trigger
    no_store_in_idle: assert property (
        @(posedge clk) disable iff (!reset_b) (state == ST_IDLE) |-> !store_en)
        else $error("store_en high while the controller is idle");

    corr_start_on_entry: assert property (
        @(posedge clk) disable iff (!reset_b)
        corr_start |-> (state == ST_CORRELATE) && ($past(state) != ST_CORRELATE))
        else $error("corr_start outside the first correlate cycle");

    done_not_busy: assert property (
        @(posedge clk) disable iff (!reset_b) done |-> !busy)
        else $error("busy high together with done");

endmodule

//--- rtl/acoustic_acq_top.sv
// Two-mic capture and lag search; results hold from done until the next run, run while busy is dropped
`timescale 1ns/1ps

module acoustic_acq_top
    import acq_sample_pkg::*;
(
    input  logic      clk,
    input  logic      reset_b,
    input  logic      run,
    input  logic      trig,
    input  logic      bit_en,
    input  logic      mic_a,
    input  logic      mic_b,
    output logic      busy,
    output logic      done,
    output lag_t      best_lag,
    output corr_sum_t best_sum
);

    logic      clear;
    logic      store_en;
    logic      sample_ready;        // From channel A only
    logic      buf_full;
    logic      corr_start;
    logic      corr_done;
    buf_addr_t rd_addr_a;
    buf_addr_t rd_addr_b;
    sample_t   rd_data_a;
    sample_t   rd_data_b;

    capture_channel chan_a_i (
        .clk          (clk),
        .reset_b      (reset_b),
        .bit_en       (bit_en),
        .data_in      (mic_a),
        .store_en     (store_en),
        .clear        (clear),
        .rd_addr      (rd_addr_a),
        .sample_ready (sample_ready),
        .buf_full     (buf_full),
        .rd_data      (rd_data_a)
    );

    // Same bit_en as A, so its status lines are redundant
    capture_channel chan_b_i (
        .clk          (clk),
        .reset_b      (reset_b),
        .bit_en       (bit_en),
        .data_in      (mic_b),
        .store_en     (store_en),
        .clear        (clear),
        .rd_addr      (rd_addr_b),
        .sample_ready (),
        .buf_full     (),
        .rd_data      (rd_data_b)
    );

    cross_correlator corr_i (
        .clk       (clk),
        .reset_b   (reset_b),
        .start     (corr_start),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .done      (corr_done),
        .best_lag  (best_lag),
        .best_sum  (best_sum)
    );

    acq_controller ctrl_i (
        .clk          (clk),
        .reset_b      (reset_b),
        .run          (run),
        .trig         (trig),
        .sample_ready (sample_ready),
        .buf_full     (buf_full),
        .corr_done    (corr_done),
        .clear        (clear),
        .store_en     (store_en),
        .corr_start   (corr_start),
        .busy         (busy),
        .done         (done)
    );

endmodule

//--- rtl/acq_controller.sv
// Uses one channel's sample_ready and buf_full; the other channel must share bit_en to stay aligned
`timescale 1ns/1ps

module acq_controller
    import acq_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset_b,
    input  logic run,
    input  logic trig,
    input  logic sample_ready,
    input  logic buf_full,
    input  logic corr_done,
    output logic clear,
    output logic store_en,
    output logic corr_start,
    output logic busy,
    output logic done
);

    acq_state_t state;
    acq_state_t next_state;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (run)
                    next_state = ST_PRE_WAIT;
            ST_PRE_WAIT:
                if (sample_ready)
                    next_state = ST_PRE_READY;
            ST_PRE_READY:
            begin
                // Trigger only counts on a sample boundary
                if (trig)
                    next_state = ST_POST_WAIT;
                else
                    next_state = ST_PRE_WAIT;
            end
            ST_POST_WAIT:
                if (sample_ready)
                    next_state = ST_POST_READY;   // Channels wrote this sample
            ST_POST_READY:
            begin
                if (buf_full)
                    next_state = ST_CORRELATE;
                else
                    next_state = ST_POST_WAIT;
            end
            ST_CORRELATE:
                if (corr_done)
                    next_state = ST_REPORT;
            ST_REPORT:
                next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    // Rewind both buffers as a capture starts
    assign clear    = (state == ST_IDLE) && run;
    assign store_en = (state == ST_POST_WAIT) || (state == ST_POST_READY);
    assign busy     = (state != ST_IDLE) && (state != ST_REPORT);
    assign done     = (state == ST_REPORT);

    // High in the first ST_CORRELATE cycle
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            corr_start <= 1'b0;
        else
            corr_start <= (state != ST_CORRELATE) && (next_state == ST_CORRELATE);
    end

endmodule

//--- rtl/cross_correlator.sv
// One product per cycle, (16+9)*8/2 = 100 cycles per run; buffers must not change while running
`timescale 1ns/1ps
`include "acq_consts.svh"

module cross_correlator
    import acq_sample_pkg::*;
(
    input  logic      clk,
    input  logic      reset_b,
    input  logic      start,
    output buf_addr_t rd_addr_a,
    output buf_addr_t rd_addr_b,
    input  sample_t   rd_data_a,
    input  sample_t   rd_data_b,
    output logic      done,
    output lag_t      best_lag,
    output corr_sum_t best_sum
);

    logic                             running;
    lag_t                             lag;        // Lag being summed
    buf_addr_t                        idx;        // Index i into buffer A
    corr_sum_t                        acc;
    corr_sum_t                        cand_sum;   // Best sum among finished lags
    lag_t                             cand_lag;

    logic signed [2*`ACQ_SAMPLE_W-1:0] prod;
    corr_sum_t                        next_acc;
    logic                             last_idx;
    logic                             last_lag;
    logic                             new_best;

    // Buffer B is read lag samples ahead of A
    assign rd_addr_a = idx;
    assign rd_addr_b = idx + buf_addr_t'(lag);

    assign prod     = rd_data_a * rd_data_b;
    assign next_acc = acc + corr_sum_t'(prod);  // Sign-extended product

    // i + lag reaches the end of B
    assign last_idx = (rd_addr_b == buf_addr_t'(`ACQ_BUF_DEPTH - 1));
    assign last_lag = (lag == lag_t'(`ACQ_NUM_LAGS - 1));

    // Lag 0 always seeds the best; later lags must beat it strictly
    assign new_best = (lag == '0) || (next_acc > cand_sum);

    // Sequencing
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            running <= 1'b0;
            lag     <= '0;
            idx     <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running <= 1'b1;
                lag     <= '0;
                idx     <= '0;
            end
            else if (running)
            begin
                if (last_idx)
                begin
                    idx <= '0;
                    lag <= lag + 1'b1;
                    if (last_lag)
                    begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end
                end
                else
                    idx <= idx + 1'b1;
            end
        end
    end

    // Accumulate and track the winner
    always_ff @(posedge clk)
    begin
        if (start)
            acc <= '0;
        else if (running)
        begin
            if (last_idx)
            begin
                acc <= '0;                           // Fresh sum for the next lag
                if (new_best)
                begin
                    cand_sum <= next_acc;
                    cand_lag <= lag;
                end
            end
            else
                acc <= next_acc;
        end
    end

    // Results only move when the last lag closes
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            best_lag <= '0;
            best_sum <= '0;
        end
        else if (running && last_idx && last_lag)
        begin
            best_lag <= new_best ? lag : cand_lag;
            best_sum <= new_best ? next_acc : cand_sum;
        end
    end

endmodule

//--- rtl/capture_channel.sv
// One mic channel; bits count from reset, so bit_en must be framed to 14-bit samples from the start
`timescale 1ns/1ps
`include "acq_consts.svh"

module capture_channel
    import acq_sample_pkg::*;
(
    input  logic      clk,
    input  logic      reset_b,
    input  logic      bit_en,
    input  logic      data_in,
    input  logic      store_en,
    input  logic      clear,
    input  buf_addr_t rd_addr,
    output logic      sample_ready,
    output logic      buf_full,
    output sample_t   rd_data
);

    sample_t   shift_reg;                    // Serial bits land here, MSB first
    bit_cnt_t  bit_cnt;                      // Position within the current sample
    buf_addr_t wr_ptr;
    sample_t   mem [`ACQ_BUF_DEPTH];

    logic      last_bit;
    logic      wr_en;

    assign last_bit = (bit_cnt == bit_cnt_t'(`ACQ_SAMPLE_W - 1));
    assign wr_en    = sample_ready && store_en && !buf_full;

    // Deserializer
    always_ff @(posedge clk)
    begin
        if (bit_en)
            shift_reg <= {shift_reg[`ACQ_SAMPLE_W-2:0], data_in};
    end

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            bit_cnt      <= '0;
            sample_ready <= 1'b0;
        end
        else
        begin
            sample_ready <= bit_en && last_bit;  // Word is complete the cycle after
            if (bit_en)
            begin
                if (last_bit)
                    bit_cnt <= '0;
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Write side of the buffer
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            wr_ptr   <= '0;
            buf_full <= 1'b0;
        end
        else if (clear)
        begin
            wr_ptr   <= '0;
            buf_full <= 1'b0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;             // Wraps to 0 after the last entry
            if (wr_ptr == buf_addr_t'(`ACQ_BUF_DEPTH - 1))
                buf_full <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= shift_reg;
    end

    // Correlator reads without a clock
    assign rd_data = mem[rd_addr];

endmodule

//--- rtl/acq_ctrl_pkg.sv
// Controller state encoding; the order follows the capture sequence, idle first
package acq_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,   // Waiting for run
        ST_PRE_WAIT   = 3'd1,   // Pre-trigger sample in flight
        ST_PRE_READY  = 3'd2,   // Sample boundary, look at trig
        ST_POST_WAIT  = 3'd3,   // Storing, sample in flight
        ST_POST_READY = 3'd4,   // Sample stored, check for full
        ST_CORRELATE  = 3'd5,   // Correlator running
        ST_REPORT     = 3'd6    // One cycle, done pulse
    } acq_state_t;

endpackage

//--- rtl/acq_sample_pkg.sv
// Data types for the capture and correlation path; widths follow acq_consts.svh
`include "acq_consts.svh"

package acq_sample_pkg;

    // One deserialized microphone word
    typedef logic signed [`ACQ_SAMPLE_W-1:0] sample_t;

    // Index into the post-trigger buffer
    typedef logic [$clog2(`ACQ_BUF_DEPTH)-1:0] buf_addr_t;

    // Correlation lag, as reported
    typedef logic [$clog2(`ACQ_NUM_LAGS)-1:0] lag_t;

    // Signed sum of products for one lag
    typedef logic signed [`ACQ_ACC_W-1:0] corr_sum_t;

    // Counts bits 0..ACQ_SAMPLE_W-1 within a sample
    typedef logic [$clog2(`ACQ_SAMPLE_W)-1:0] bit_cnt_t;

endpackage

//--- rtl/acq_consts.svh
// Sizing for the capture path; ACQ_ACC_W must hold 16 full-scale products of two samples
`ifndef ACQ_CONSTS_SVH
`define ACQ_CONSTS_SVH

// Bits per microphone sample, two's complement, sent MSB first
`define ACQ_SAMPLE_W 14

// Samples kept per channel once the trigger is taken
`define ACQ_BUF_DEPTH 16

// Lags tried by the correlator, 0 up to ACQ_NUM_LAGS-1
`define ACQ_NUM_LAGS 8

// Width of the running product sum
// 16 * (2^13)^2 = 2^30, so 32 bits leaves headroom
`define ACQ_ACC_W 32

`endif
